//--- rtl/mips_defs.svh
// MIPS core widths and constants
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// ============================================================
// datapath widths
// ============================================================
`define MIPS_XLEN    32   // data and address width.
`define MIPS_REG_AW  5    // register number width.

// ============================================================
// fetch
// ============================================================
`define MIPS_RESET_PC 32'h0000_0000  // first fetch address.

`endif

//--- rtl/mips_pkg.sv
// MIPS core shared types
`default_nettype none

`include "mips_defs.svh"

package mips_pkg;

    // primary opcodes of the supported subset.
    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011,
        OP_BEQ   = 6'b000100,
        OP_ADDI  = 6'b001000,
        OP_J     = 6'b000010
    } opcode_e;

    // r-type function field.
    typedef enum logic [5:0] {
        FN_ADD = 6'b100000,
        FN_SUB = 6'b100010,
        FN_AND = 6'b100100,
        FN_OR  = 6'b100101,
        FN_SLT = 6'b101010
    } funct_e;

    typedef enum logic [2:0] {
        ALU_AND = 3'b000,
        ALU_OR  = 3'b001,
        ALU_ADD = 3'b010,
        ALU_NOP = 3'b101,
        ALU_SUB = 3'b110,
        ALU_SLT = 3'b111
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REG = 2'b00,  // operand from decode.
        FWD_WB  = 2'b01,  // writeback result.
        FWD_MEM = 2'b10   // memory stage alu result.
    } fwd_e;

    typedef struct packed {
        logic    regwrite;
        logic    memtoreg;
        logic    memwrite;
        logic    alusrc;
        logic    regdst;
        alu_op_e alu_op;
    } ex_ctrl_t;

    typedef struct packed {
        logic                    regwrite;
        logic                    memtoreg;
        logic                    memwrite;
        logic [`MIPS_XLEN-1:0]   aluout;
        logic [`MIPS_XLEN-1:0]   writedata;
        logic [`MIPS_REG_AW-1:0] wreg;
    } mem_stage_t;

endpackage

`default_nettype wire

//--- rtl/mips_regfile.sv
// MIPS register file
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module mips_regfile (
    input  logic                    clk,
    input  logic                    we,
    input  logic [`MIPS_REG_AW-1:0] ra1,
    input  logic [`MIPS_REG_AW-1:0] ra2,
    input  logic [`MIPS_REG_AW-1:0] wa,
    input  logic [`MIPS_XLEN-1:0]   wd,
    output logic [`MIPS_XLEN-1:0]   rd1,
    output logic [`MIPS_XLEN-1:0]   rd2
);

    logic [`MIPS_XLEN-1:0] rf [0:(1 << `MIPS_REG_AW)-1];

    always_ff @(posedge clk) begin
        if (we) begin
            rf[wa] <= wd;
        end
    end

    // writeback data is bypassed onto a matching read.
    assign rd1 = (ra1 == '0)             ? '0 :
                 (we && (wa == ra1))     ? wd : rf[ra1];
    assign rd2 = (ra2 == '0)             ? '0 :
                 (we && (wa == ra2))     ? wd : rf[ra2];

endmodule

`default_nettype wire

//--- rtl/mips_fetch.sv
// MIPS fetch stage
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module mips_fetch (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,
    input  logic                  pcsrc,
    input  logic                  jump,
    input  logic [`MIPS_XLEN-1:0] branch_target,
    input  logic [`MIPS_XLEN-1:0] jump_target,
    input  logic [`MIPS_XLEN-1:0] instr,
    output logic [`MIPS_XLEN-1:0] pc,
    output logic [`MIPS_XLEN-1:0] instr_d,
    output logic [`MIPS_XLEN-1:0] pcplus4_d,
    output logic                  valid_d
);

    logic [`MIPS_XLEN-1:0] pcplus4;
    logic [`MIPS_XLEN-1:0] pc_next;
    logic                  redirect;

    assign pcplus4  = pc + `MIPS_XLEN'd4;
    assign redirect = pcsrc | jump;
    assign pc_next  = jump  ? jump_target :
                      pcsrc ? branch_target : pcplus4;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `MIPS_RESET_PC;
        end else if (!stall) begin
            pc <= pc_next;
        end
    end

    // fetch/decode register. a stall holds a pending redirect too.
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_d <= 1'b0;
        end else if (!stall) begin
            valid_d <= !redirect;   // kill the wrong-path slot.
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            instr_d   <= instr;
            pcplus4_d <= pcplus4;
        end
    end

endmodule

`default_nettype wire

//--- rtl/mips_decode.sv
// MIPS decode stage
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module mips_decode (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`MIPS_XLEN-1:0]   instr_d,
    input  logic [`MIPS_XLEN-1:0]   pcplus4_d,
    input  logic                    valid_d,
    input  logic                    fwd_a_d,
    input  logic                    fwd_b_d,
    input  logic [`MIPS_XLEN-1:0]   aluout_m,
    input  logic                    wb_we,
    input  logic [`MIPS_REG_AW-1:0] wb_reg,
    input  logic [`MIPS_XLEN-1:0]   wb_data,
    output mips_pkg::ex_ctrl_t      ctrl,
    output logic [`MIPS_REG_AW-1:0] rs,
    output logic [`MIPS_REG_AW-1:0] rt,
    output logic [`MIPS_REG_AW-1:0] rd,
    output logic [`MIPS_XLEN-1:0]   opa,
    output logic [`MIPS_XLEN-1:0]   opb,
    output logic [`MIPS_XLEN-1:0]   imm,
    output logic                    branch,
    output logic                    pcsrc,
    output logic                    jump,
    output logic [`MIPS_XLEN-1:0]   branch_target,
    output logic [`MIPS_XLEN-1:0]   jump_target
);

    mips_pkg::opcode_e     op;
    mips_pkg::funct_e      fn;
    logic [`MIPS_XLEN-1:0] rd1;
    logic [`MIPS_XLEN-1:0] rd2;

    assign op = mips_pkg::opcode_e'(instr_d[31:26]);
    assign fn = mips_pkg::funct_e'(instr_d[5:0]);
    assign rs = instr_d[25:21];
    assign rt = instr_d[20:16];
    assign rd = instr_d[15:11];

    assign imm           = {{(`MIPS_XLEN-16){instr_d[15]}}, instr_d[15:0]};
    assign branch_target = pcplus4_d + {imm[`MIPS_XLEN-3:0], 2'b00};
    assign jump_target   = {pcplus4_d[`MIPS_XLEN-1:28], instr_d[25:0], 2'b00};

    mips_regfile i_regfile (
        .clk (clk),
        .we  (wb_we && !rst),   // no writeback while in reset.
        .ra1 (rs),
        .ra2 (rt),
        .wa  (wb_reg),
        .wd  (wb_data),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    // memory stage result overrides the register read.
    assign opa   = fwd_a_d ? aluout_m : rd1;
    assign opb   = fwd_b_d ? aluout_m : rd2;
    assign pcsrc = branch && (opa == opb);

    // ============================================================
    // main and alu control
    // ============================================================
    always_comb begin
        ctrl   = '0;
        branch = 1'b0;
        jump   = 1'b0;
        if (valid_d) begin
            case (op)
                mips_pkg::OP_RTYPE: begin
                    ctrl.regwrite = 1'b1;
                    ctrl.regdst   = 1'b1;
                    case (fn)
                        mips_pkg::FN_ADD: ctrl.alu_op = mips_pkg::ALU_ADD;
                        mips_pkg::FN_SUB: ctrl.alu_op = mips_pkg::ALU_SUB;
                        mips_pkg::FN_AND: ctrl.alu_op = mips_pkg::ALU_AND;
                        mips_pkg::FN_OR:  ctrl.alu_op = mips_pkg::ALU_OR;
                        mips_pkg::FN_SLT: ctrl.alu_op = mips_pkg::ALU_SLT;
                        default:          ctrl.alu_op = mips_pkg::ALU_NOP;
                    endcase
                end
                mips_pkg::OP_LW: begin
                    ctrl.regwrite = 1'b1;
                    ctrl.memtoreg = 1'b1;
                    ctrl.alusrc   = 1'b1;
                    ctrl.alu_op   = mips_pkg::ALU_ADD;
                end
                mips_pkg::OP_SW: begin
                    ctrl.memwrite = 1'b1;
                    ctrl.alusrc   = 1'b1;
                    ctrl.alu_op   = mips_pkg::ALU_ADD;
                end
                mips_pkg::OP_ADDI: begin
                    ctrl.regwrite = 1'b1;
                    ctrl.alusrc   = 1'b1;
                    ctrl.alu_op   = mips_pkg::ALU_ADD;
                end
                mips_pkg::OP_BEQ: branch = 1'b1;   // compared here, not in the alu.
                mips_pkg::OP_J:   jump   = 1'b1;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/mips_hazard.sv
// MIPS hazard and forwarding unit
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module mips_hazard (
    input  logic [`MIPS_REG_AW-1:0] rs_d,
    input  logic [`MIPS_REG_AW-1:0] rt_d,
    input  logic                    branch_d,
    input  logic [`MIPS_REG_AW-1:0] rs_e,
    input  logic [`MIPS_REG_AW-1:0] rt_e,
    input  logic [`MIPS_REG_AW-1:0] wreg_e,
    input  logic                    regwrite_e,
    input  logic                    memtoreg_e,
    input  logic [`MIPS_REG_AW-1:0] wreg_m,
    input  logic                    regwrite_m,
    input  logic                    memtoreg_m,
    input  logic [`MIPS_REG_AW-1:0] wreg_w,
    input  logic                    regwrite_w,
    output logic                    fwd_a_d,
    output logic                    fwd_b_d,
    output mips_pkg::fwd_e          fwd_a_e,
    output mips_pkg::fwd_e          fwd_b_e,
    output logic                    stall,
    output logic                    flush
);

    logic lw_stall;
    logic branch_stall;

    // memory wins over writeback; register zero is never forwarded.
    function automatic mips_pkg::fwd_e sel_e(input logic [`MIPS_REG_AW-1:0] src);
        if (src != '0 && regwrite_m && src == wreg_m) begin
            return mips_pkg::FWD_MEM;
        end else if (src != '0 && regwrite_w && src == wreg_w) begin
            return mips_pkg::FWD_WB;
        end
        return mips_pkg::FWD_REG;
    endfunction

    // destination is one of the decode sources.
    function automatic logic reads(input logic [`MIPS_REG_AW-1:0] dst);
        return (dst != '0) && (dst == rs_d || dst == rt_d);
    endfunction

    assign fwd_a_e = sel_e(rs_e);
    assign fwd_b_e = sel_e(rt_e);

    // a load's alu result is only its address.
    assign fwd_a_d = (rs_d != '0) && regwrite_m && !memtoreg_m && (rs_d == wreg_m);
    assign fwd_b_d = (rt_d != '0) && regwrite_m && !memtoreg_m && (rt_d == wreg_m);

    // ============================================================
    // stalls
    // ============================================================
    assign lw_stall     = memtoreg_e && reads(wreg_e);
    assign branch_stall = branch_d && ((regwrite_e && reads(wreg_e)) ||
                                       (memtoreg_m && reads(wreg_m)));

    assign stall = lw_stall | branch_stall;
    assign flush = stall;   // bubble into execute.

endmodule

`default_nettype wire

//--- rtl/mips_execute.sv
// MIPS execute stage
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module mips_execute (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  mips_pkg::ex_ctrl_t      ctrl,
    input  logic [`MIPS_REG_AW-1:0] rs,
    input  logic [`MIPS_REG_AW-1:0] rt,
    input  logic [`MIPS_REG_AW-1:0] rd,
    input  logic [`MIPS_XLEN-1:0]   opa,
    input  logic [`MIPS_XLEN-1:0]   opb,
    input  logic [`MIPS_XLEN-1:0]   imm,
    input  mips_pkg::fwd_e          fwd_a,
    input  mips_pkg::fwd_e          fwd_b,
    input  logic [`MIPS_XLEN-1:0]   aluout_m,
    input  logic [`MIPS_XLEN-1:0]   result_w,
    output logic [`MIPS_REG_AW-1:0] rs_e,
    output logic [`MIPS_REG_AW-1:0] rt_e,
    output logic [`MIPS_REG_AW-1:0] wreg_e,
    output logic                    regwrite_e,
    output logic                    memtoreg_e,
    output mips_pkg::mem_stage_t    mem
);

    mips_pkg::ex_ctrl_t      ctrl_e;
    logic [`MIPS_REG_AW-1:0] rd_e;
    logic [`MIPS_XLEN-1:0]   opa_e;
    logic [`MIPS_XLEN-1:0]   opb_e;
    logic [`MIPS_XLEN-1:0]   imm_e;
    logic [`MIPS_XLEN-1:0]   srca;
    logic [`MIPS_XLEN-1:0]   fwdb;
    logic [`MIPS_XLEN-1:0]   srcb;
    logic [`MIPS_XLEN-1:0]   alu_y;

    function automatic logic [`MIPS_XLEN-1:0] pick(input mips_pkg::fwd_e sel,
                                                   input logic [`MIPS_XLEN-1:0] reg_val);
        case (sel)
            mips_pkg::FWD_MEM: return aluout_m;
            mips_pkg::FWD_WB:  return result_w;
            default:           return reg_val;
        endcase
    endfunction

    // ============================================================
    // decode/execute register
    // ============================================================
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            ctrl_e <= '0;
            rs_e   <= '0;
            rt_e   <= '0;
            rd_e   <= '0;
        end else begin
            ctrl_e <= ctrl;
            rs_e   <= rs;
            rt_e   <= rt;
            rd_e   <= rd;
        end
        opa_e <= opa;
        opb_e <= opb;
        imm_e <= imm;
    end

    assign srca   = pick(fwd_a, opa_e);
    assign fwdb   = pick(fwd_b, opb_e);   // also the store data.
    assign srcb   = ctrl_e.alusrc ? imm_e : fwdb;
    assign wreg_e = ctrl_e.regdst ? rd_e : rt_e;

    assign regwrite_e = ctrl_e.regwrite;
    assign memtoreg_e = ctrl_e.memtoreg;

    always_comb begin
        case (ctrl_e.alu_op)
            mips_pkg::ALU_ADD: alu_y = srca + srcb;
            mips_pkg::ALU_SUB: alu_y = srca - srcb;
            mips_pkg::ALU_AND: alu_y = srca & srcb;
            mips_pkg::ALU_OR:  alu_y = srca | srcb;
            mips_pkg::ALU_SLT: alu_y = {{(`MIPS_XLEN-1){1'b0}}, srca < srcb};  // unsigned.
            default:           alu_y = '0;
        endcase
    end

    // execute/memory register.
    always_ff @(posedge clk) begin
        if (rst) begin
            mem.regwrite <= 1'b0;
            mem.memtoreg <= 1'b0;
            mem.memwrite <= 1'b0;
        end else begin
            mem.regwrite <= ctrl_e.regwrite;
            mem.memtoreg <= ctrl_e.memtoreg;
            mem.memwrite <= ctrl_e.memwrite;
        end
        mem.aluout    <= alu_y;
        mem.writedata <= fwdb;
        mem.wreg      <= wreg_e;
    end

endmodule

`default_nettype wire

//--- rtl/mips_core.sv
// MIPS five-stage pipeline core
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module mips_core (
    input  logic                  clk,
    input  logic                  rst,
    output logic [`MIPS_XLEN-1:0] pc,
    input  logic [`MIPS_XLEN-1:0] instr,
    output logic [`MIPS_XLEN-1:0] aluout,
    output logic [`MIPS_XLEN-1:0] writedata,
    output logic                  memwrite,
    input  logic [`MIPS_XLEN-1:0] readdata
);

    // fetch/decode
    logic [`MIPS_XLEN-1:0]   instr_d;
    logic [`MIPS_XLEN-1:0]   pcplus4_d;
    logic                    valid_d;
    logic                    pcsrc;
    logic                    jump;
    logic [`MIPS_XLEN-1:0]   branch_target;
    logic [`MIPS_XLEN-1:0]   jump_target;

    // decode to execute
    mips_pkg::ex_ctrl_t      ctrl_d;
    logic [`MIPS_REG_AW-1:0] rs_d;
    logic [`MIPS_REG_AW-1:0] rt_d;
    logic [`MIPS_REG_AW-1:0] rd_d;
    logic [`MIPS_XLEN-1:0]   opa_d;
    logic [`MIPS_XLEN-1:0]   opb_d;
    logic [`MIPS_XLEN-1:0]   imm_d;
    logic                    branch_d;

    // hazard unit
    logic                    fwd_a_d;
    logic                    fwd_b_d;
    mips_pkg::fwd_e          fwd_a_e;
    mips_pkg::fwd_e          fwd_b_e;
    logic                    stall;
    logic                    flush;

    // execute and later
    logic [`MIPS_REG_AW-1:0] rs_e;
    logic [`MIPS_REG_AW-1:0] rt_e;
    logic [`MIPS_REG_AW-1:0] wreg_e;
    logic                    regwrite_e;
    logic                    memtoreg_e;
    mips_pkg::mem_stage_t    mem;

    logic                    regwrite_w;
    logic                    memtoreg_w;
    logic [`MIPS_XLEN-1:0]   aluout_w;
    logic [`MIPS_XLEN-1:0]   readdata_w;
    logic [`MIPS_REG_AW-1:0] wreg_w;
    logic [`MIPS_XLEN-1:0]   result_w;

    mips_fetch i_fetch (
        .clk (clk), .rst (rst), .stall (stall),
        .pcsrc (pcsrc), .jump (jump),
        .branch_target (branch_target), .jump_target (jump_target),
        .instr (instr), .pc (pc),
        .instr_d (instr_d), .pcplus4_d (pcplus4_d), .valid_d (valid_d)
    );

    mips_decode i_decode (
        .clk (clk), .rst (rst),
        .instr_d (instr_d), .pcplus4_d (pcplus4_d), .valid_d (valid_d),
        .fwd_a_d (fwd_a_d), .fwd_b_d (fwd_b_d), .aluout_m (mem.aluout),
        .wb_we (regwrite_w), .wb_reg (wreg_w), .wb_data (result_w),
        .ctrl (ctrl_d), .rs (rs_d), .rt (rt_d), .rd (rd_d),
        .opa (opa_d), .opb (opb_d), .imm (imm_d), .branch (branch_d),
        .pcsrc (pcsrc), .jump (jump),
        .branch_target (branch_target), .jump_target (jump_target)
    );

    mips_hazard i_hazard (
        .rs_d (rs_d), .rt_d (rt_d), .branch_d (branch_d),
        .rs_e (rs_e), .rt_e (rt_e), .wreg_e (wreg_e),
        .regwrite_e (regwrite_e), .memtoreg_e (memtoreg_e),
        .wreg_m (mem.wreg), .regwrite_m (mem.regwrite), .memtoreg_m (mem.memtoreg),
        .wreg_w (wreg_w), .regwrite_w (regwrite_w),
        .fwd_a_d (fwd_a_d), .fwd_b_d (fwd_b_d),
        .fwd_a_e (fwd_a_e), .fwd_b_e (fwd_b_e),
        .stall (stall), .flush (flush)
    );

    mips_execute i_execute (
        .clk (clk), .rst (rst), .flush (flush),
        .ctrl (ctrl_d), .rs (rs_d), .rt (rt_d), .rd (rd_d),
        .opa (opa_d), .opb (opb_d), .imm (imm_d),
        .fwd_a (fwd_a_e), .fwd_b (fwd_b_e),
        .aluout_m (mem.aluout), .result_w (result_w),
        .rs_e (rs_e), .rt_e (rt_e), .wreg_e (wreg_e),
        .regwrite_e (regwrite_e), .memtoreg_e (memtoreg_e),
        .mem (mem)
    );

    // ============================================================
    // memory stage ports and memory/writeback register
    // ============================================================
    assign aluout    = mem.aluout;
    assign writedata = mem.writedata;
    assign memwrite  = mem.memwrite;

    always_ff @(posedge clk) begin
        if (rst) begin
            regwrite_w <= 1'b0;
            memtoreg_w <= 1'b0;
        end else begin
            regwrite_w <= mem.regwrite;
            memtoreg_w <= mem.memtoreg;
        end
        aluout_w   <= mem.aluout;
        readdata_w <= readdata;   // sampled from the combinational read.
        wreg_w     <= mem.wreg;
    end

    assign result_w = memtoreg_w ? readdata_w : aluout_w;

endmodule

`default_nettype wire

//--- verification/mips_core_assertions.sv
// MIPS core bound checks
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module mips_core_assertions (
    input logic                  clk,
    input logic                  rst,
    input logic [`MIPS_XLEN-1:0] pc,
    input logic                  memwrite,
    input logic [`MIPS_XLEN-1:0] aluout,
    input logic [`MIPS_XLEN-1:0] writedata
);

    int unsigned fail_count;   // polled by the testbench.

    initial fail_count = 0;

    // ============================================================
    // reset
    // ============================================================
    reset_pc: assert property (@(posedge clk) rst |=> (pc == `MIPS_RESET_PC))
        else begin
            $error("pc not at the reset address after a reset cycle");
            fail_count++;
        end

    reset_store: assert property (@(posedge clk) rst |=> !memwrite)
        else begin
            $error("store strobe high after a reset cycle");
            fail_count++;
        end

    // ============================================================
    // fetch and store port
    // ============================================================
    pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else begin
            $error("pc is not word aligned");
            fail_count++;
        end

    store_known: assert property (@(posedge clk) disable iff (rst)
                                  !$isunknown(memwrite) &&
                                  (memwrite -> !$isunknown({aluout, writedata})))
        else begin
            $error("store port carries unknown bits");
            fail_count++;
        end

    store_aligned: assert property (@(posedge clk) disable iff (rst)
                                    memwrite |-> (aluout[1:0] == 2'b00))
        else begin
            $error("store address is not word aligned");
            fail_count++;
        end

endmodule

`default_nettype wire

//--- verification/mips_core_tb.sv
// MIPS core testbench
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module mips_core_tb;

    localparam int          HALF_PERIOD  = 5;
    localparam int          RESET_CYCLES = 16;
    localparam int          DRAIN_CYCLES = 8;    // quiet cycles checked after the last store.
    localparam int          ROM_WORDS    = 64;
    localparam int          RAM_WORDS    = 64;
    localparam int          STEP_LIMIT   = 1000; // reference model runaway guard.
    localparam logic [31:0] SEED         = 32'hc591a1e4;
    localparam logic [15:0] POISON_ADDR  = 16'h00fc;

    // MIPS ISA encodings.
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] FN_ADD   = 6'h20;
    localparam logic [5:0] FN_SUB   = 6'h22;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_SLT   = 6'h2a;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } store_t;

    logic                  clk;
    logic                  rst;
    logic [`MIPS_XLEN-1:0] pc;
    logic [`MIPS_XLEN-1:0] instr;
    logic [`MIPS_XLEN-1:0] aluout;
    logic [`MIPS_XLEN-1:0] writedata;
    logic                  memwrite;
    logic [`MIPS_XLEN-1:0] readdata;

    logic [31:0] rom [0:ROM_WORDS-1];
    logic [31:0] ram [0:RAM_WORDS-1];
    logic [31:0] model_regs [0:31];
    logic [31:0] model_ram [0:RAM_WORDS-1];
    store_t      store_q [$];       // expected stores, oldest first.
    logic [31:0] final_pc;
    int unsigned model_steps;
    int unsigned cycle_limit;
    int unsigned cycle_count = 0;

    mips_core i_mips_core (
        .clk       (clk),
        .rst       (rst),
        .pc        (pc),
        .instr     (instr),
        .aluout    (aluout),
        .writedata (writedata),
        .memwrite  (memwrite),
        .readdata  (readdata)
    );

    bind mips_core mips_core_assertions i_assertions (
        .clk       (clk),
        .rst       (rst),
        .pc        (pc),
        .memwrite  (memwrite),
        .aluout    (aluout),
        .writedata (writedata)
    );

    always #HALF_PERIOD clk = ~clk;

    // ============================================================
    // memories
    // ============================================================
    assign instr    = rom[pc[7:2]];       // combinational fetch.
    assign readdata = ram[aluout[7:2]];

    always @(posedge clk) begin
        if (!rst && memwrite) begin
            ram[aluout[7:2]] <= writedata;
        end
    end

    task automatic stop_with_failure();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        stop_with_failure();
    endtask

    task automatic flag_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
        stop_with_failure();
    endtask

    function automatic logic [31:0] r_instr(input logic [5:0] fn, input logic [4:0] rd,
                                            input logic [4:0] rs, input logic [4:0] rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_instr(input logic [5:0] op, input logic [4:0] rt,
                                            input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_instr(input logic [25:0] word);
        return {OP_J, word};
    endfunction

    task automatic load_program();
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = '0;   // nop.
        end
        rom[0]  = i_instr(OP_LW, 5'd1, 5'd0, 16'd0);
        rom[1]  = i_instr(OP_LW, 5'd2, 5'd0, 16'd4);
        rom[2]  = r_instr(FN_ADD, 5'd3, 5'd1, 5'd2);      // load-use.
        rom[3]  = i_instr(OP_SW, 5'd3, 5'd0, 16'd64);
        rom[4]  = i_instr(OP_ADDI, 5'd4, 5'd0, 16'h0123);
        rom[5]  = i_instr(OP_ADDI, 5'd5, 5'd4, 16'hfff9);  // from memory stage.
        rom[6]  = r_instr(FN_SUB, 5'd6, 5'd5, 5'd4);      // memory and writeback.
        rom[7]  = r_instr(FN_ADD, 5'd7, 5'd6, 5'd6);
        rom[8]  = i_instr(OP_SW, 5'd7, 5'd0, 16'd68);
        rom[9]  = i_instr(OP_SW, 5'd6, 5'd0, 16'd72);
        rom[10] = i_instr(OP_LW, 5'd8, 5'd0, 16'd8);
        rom[11] = i_instr(OP_LW, 5'd9, 5'd0, 16'd12);
        rom[12] = r_instr(FN_AND, 5'd10, 5'd8, 5'd9);
        rom[13] = r_instr(FN_OR,  5'd11, 5'd8, 5'd9);
        rom[14] = r_instr(FN_SLT, 5'd12, 5'd8, 5'd9);
        rom[15] = r_instr(FN_SLT, 5'd13, 5'd9, 5'd8);
        rom[16] = i_instr(OP_SW, 5'd10, 5'd0, 16'd76);
        rom[17] = i_instr(OP_SW, 5'd11, 5'd0, 16'd80);
        rom[18] = i_instr(OP_SW, 5'd12, 5'd0, 16'd84);
        rom[19] = i_instr(OP_SW, 5'd13, 5'd0, 16'd88);
        rom[20] = r_instr(FN_ADD, 5'd14, 5'd1, 5'd0);
        rom[21] = i_instr(OP_BEQ, 5'd1, 5'd14, 16'd1);     // taken.
        rom[22] = i_instr(OP_SW, 5'd14, 5'd0, POISON_ADDR);
        rom[23] = r_instr(FN_ADD, 5'd15, 5'd1, 5'd2);
        rom[24] = i_instr(OP_BEQ, 5'd1, 5'd15, 16'd1);     // falls through.
        rom[25] = i_instr(OP_SW, 5'd15, 5'd0, 16'd92);
        rom[26] = i_instr(OP_LW, 5'd16, 5'd0, 16'd0);
        rom[27] = i_instr(OP_BEQ, 5'd1, 5'd16, 16'd1);     // waits on the load.
        rom[28] = i_instr(OP_SW, 5'd14, 5'd0, POISON_ADDR);
        rom[29] = i_instr(OP_SW, 5'd16, 5'd0, 16'd96);
        rom[30] = j_instr(26'd32);
        rom[31] = i_instr(OP_SW, 5'd14, 5'd0, POISON_ADDR);
        rom[32] = i_instr(OP_ADDI, 5'd17, 5'd0, 16'h005a);
        rom[33] = i_instr(OP_SW, 5'd17, 5'd0, 16'd100);
        rom[34] = j_instr(26'd34);                         // self-jump.
        rom[35] = i_instr(OP_SW, 5'd14, 5'd0, POISON_ADDR);
    endtask

    task automatic fill_data_ram();
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram[i] = (i < 8) ? $urandom : (32'hd00d_0000 ^ (i << 2));
        end
    endtask

    // ============================================================
    // reference model, one instruction per step
    // ============================================================
    task automatic run_reference();
        logic [31:0] mpc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] nxt;
        logic [31:0] res;
        logic        writes;
        logic        halted;
        store_t      st;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            model_ram[i] = ram[i];
        end
        mpc         = `MIPS_RESET_PC;
        model_steps = 0;
        halted      = 1'b0;
        while (!halted && model_steps < STEP_LIMIT) begin
            ins    = rom[mpc[7:2]];
            a      = model_regs[ins[25:21]];
            b      = model_regs[ins[20:16]];
            sext   = {{16{ins[15]}}, ins[15:0]};
            nxt    = mpc + 32'd4;
            writes = 1'b1;
            res    = '0;
            model_steps++;
            case (ins[31:26])
                OP_RTYPE: begin
                    case (ins[5:0])
                        FN_ADD:  res = a + b;
                        FN_SUB:  res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_SLT:  res = {31'd0, a < b};   // unsigned compare.
                        default: writes = 1'b0;
                    endcase
                    if (writes && ins[15:11] != 5'd0) model_regs[ins[15:11]] = res;
                end
                OP_ADDI: if (ins[20:16] != 5'd0) model_regs[ins[20:16]] = a + sext;
                OP_LW: begin
                    res = a + sext;
                    if (ins[20:16] != 5'd0) model_regs[ins[20:16]] = model_ram[res[7:2]];
                end
                OP_SW: begin
                    st.addr = a + sext;
                    st.data = b;
                    store_q.push_back(st);
                    model_ram[st.addr[7:2]] = b;
                end
                OP_BEQ: if (a == b) nxt = nxt + (sext << 2);
                OP_J: begin
                    nxt    = {nxt[31:28], ins[25:0], 2'b00};
                    halted = (nxt == mpc);
                end
                default: ;
            endcase
            mpc = nxt;
        end
        final_pc = mpc;
        if (!halted) abort_run("reference model never reached a self-jump");
    endtask

    // store port against the model's ordered list.
    always @(posedge clk) begin : check_stores
        store_t exp_store;
        if (!rst && memwrite) begin
            assert (store_q.size() != 0)
                else abort_run("store seen after all expected stores");
            exp_store = store_q.pop_front();
            assert (aluout == exp_store.addr)
                else flag_mismatch("aluout", aluout, exp_store.addr);
            assert (writedata == exp_store.data)
                else flag_mismatch("writedata", writedata, exp_store.data);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            abort_run($sformatf("timeout: final jump not reached in %0d cycles", cycle_limit));
        end else if (i_mips_core.i_assertions.fail_count != 0) begin
            abort_run("a bound assertion on the core failed");
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        void'($urandom(SEED));
        load_program();
        fill_data_ram();
        run_reference();
        cycle_limit = 4 * model_steps + RESET_CYCLES + DRAIN_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        do begin
            @(negedge clk);
        end while (!(pc == final_pc && store_q.size() == 0));
        repeat (DRAIN_CYCLES) begin
            @(negedge clk);
            assert (memwrite == 1'b0)
                else abort_run("store port active after the final jump");
        end
        if (i_mips_core.i_assertions.fail_count == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            abort_run("a bound assertion on the core failed");
        end
    end

endmodule

`default_nettype wire

//--- mips_core.f
+incdir+rtl
rtl/mips_pkg.sv
rtl/mips_regfile.sv
rtl/mips_fetch.sv
rtl/mips_decode.sv
rtl/mips_hazard.sv
rtl/mips_execute.sv
rtl/mips_core.sv
verification/mips_core_assertions.sv
verification/mips_core_tb.sv

//--- Makefile
# Verilator build and run for the MIPS core testbench

VERILATOR ?= verilator
TOP       ?= mips_core_tb
FILELIST  ?= mips_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
SIM_ARGS  ?= +verilator+error+limit+100

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(SIM_BIN): $(SOURCES) $(FILELIST) rtl/mips_defs.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)
